// File: Bender.yml
package:
  name: kanji_device

sources:
  - rtl/kanji_pkg.sv
  - rtl/io_port_decoder.sv
  - rtl/kanji_addr_gen.sv
  - rtl/font_mem_port.sv
  - rtl/kanji_device.sv
  - target: simulation
    files:
      - dv/font_mem_model.sv
      - dv/kanji_tb.sv

// File: dv/font_mem_model.sv
/*
 * Font memory responder for the kanji device testbench.
 * Answers each request after a random delay with a byte made from the XOR
 * of the three low address bytes, following the four-phase handshake.
 */
`timescale 1ns/1ns

module font_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_req,
    input  kanji_pkg::mem_addr_t mem_addr,
    output logic                 mem_ack,
    output logic [7:0]           mem_rdata
);

    integer seed;
    int     wait_cycles;
    logic   armed;

    initial begin
        seed      = 32'hf3cb_78dc;
        mem_ack   = 1'b0;
        mem_rdata = 8'h00;
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_ack     <= 1'b0;
            armed       <= 1'b0;
            wait_cycles <= 0;
        end else if (mem_ack) begin
            // The ack stays up until the port drops its request
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req && !armed) begin
            // Draw the delay once per request
            armed       <= 1'b1;
            wait_cycles <= $unsigned($random(seed)) % 6;
        end else if (armed) begin
            if (wait_cycles == 0) begin
                armed     <= 1'b0;
                mem_ack   <= 1'b1;
                mem_rdata <= mem_addr[7:0] ^ mem_addr[15:8] ^ mem_addr[23:16];
            end else begin
                wait_cycles <= wait_cycles - 1;
            end
        end
    end

endmodule

// File: dv/kanji_tb.sv
/*
 * Testbench for the kanji font device.
 * Drives CPU I/O accesses on the falling edge, mirrors both bank registers
 * in a reference model and checks read bytes and the memory handshake.
 */
`timescale 1ns/1ns

module kanji_tb;

    import kanji_pkg::*;

    logic       clk;
    logic       reset;
    cpu_bus_t   cpu;
    kanji_cfg_t cfg;
    logic       mem_ack;
    logic [7:0] mem_rdata;
    logic       mem_req;
    mem_addr_t  mem_addr;
    logic [7:0] rd_data;
    logic       rd_valid;
    logic       busy;

    // Reference copies of the two bank registers
    mem_addr_t  ref_bank1;
    mem_addr_t  ref_bank2;
    // High from a read strobe until the device is idle again
    logic       read_pending;
    int         errors;
    int         checks;
    int         tests;
    int         test_errors;

    kanji_device kanji_device_inst (.*);

    font_mem_model mem_model_inst (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // A new request starts only once the previous ack has dropped
    assert property (@(posedge clk) disable iff (reset) $rose(mem_req) |-> !mem_ack)
        else report_failure("mem_req rose while mem_ack was still high");
    // Request and address hold until the memory answers
    assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
        else report_failure("mem_req or mem_addr changed before mem_ack");
    // Without a pending read the device stays quiet
    assert property (@(posedge clk) disable iff (reset)
        !read_pending |-> !mem_req && !busy && !rd_valid)
        else report_failure("memory, busy or read activity without a pending read");
    // Strobes during busy never reach the address generator
    assert property (@(posedge clk) disable iff (reset)
        cpu.req && busy |=> !kanji_device_inst.cmd.wr && !kanji_device_inst.cmd.rd)
        else report_failure("a strobe was accepted while busy was high");

    // One I/O strobe, held for a single clock
    task automatic strobe(input logic rd, input logic wr, input logic m1,
                          input io_port_t addr, input logic [7:0] data);
        @(negedge clk);
        cpu = '{req: 1'b1, iorq: 1'b1, m1: m1, rd: rd, wr: wr, addr: addr, wdata: data};
        @(negedge clk);
        cpu = '0;
    endtask

    task automatic io_write(input logic [1:0] offset, input logic [7:0] data);
        strobe(1'b0, 1'b1, 1'b0, cfg.port | io_port_t'(offset), data);
        case (offset)
            2'd0: ref_bank1[10:5] = data[5:0];
            2'd1: ref_bank1[16:11] = data[5:0];
            2'd2: ref_bank2[11:5] = cfg.hangul ? data[6:0] : {1'b0, data[5:0]};
            default: ref_bank2[16:11] = data[5:0];
        endcase
    endtask

    task automatic io_read(input logic [1:0] offset);
        mem_addr_t  exp_addr;
        mem_addr_t  size_mask;
        logic       exp_blank;
        logic [7:0] exp_data;
        logic       req_seen;
        int         waited;
        exp_blank = 1'b1;
        exp_addr  = cfg.mem_base;
        size_mask = (mem_addr_t'(cfg.mem_size) * 16384) - 1;
        if (offset == 2'd1) begin
            exp_blank = 1'b0;
            exp_addr  = cfg.mem_base + (ref_bank1 & size_mask);
            ref_bank1 = {ref_bank1[26:5], ref_bank1[4:0] + 5'd1};
        end else if (offset == 2'd3) begin
            // The second bank only exists in a 256 KB font
            if (cfg.mem_size == 8'h10) begin
                exp_blank = 1'b0;
                exp_addr  = cfg.mem_base + ref_bank2;
            end
            ref_bank2 = {ref_bank2[26:5], ref_bank2[4:0] + 5'd1};
        end
        exp_data = exp_blank ? 8'hff : exp_addr[7:0] ^ exp_addr[15:8] ^ exp_addr[23:16];
        read_pending = 1'b1;
        req_seen = 1'b0;
        waited = 0;
        strobe(1'b1, 1'b0, 1'b0, cfg.port | io_port_t'(offset), 8'h00);
        while (!rd_valid && waited < 40) begin
            @(negedge clk);
            req_seen |= mem_req;
            waited++;
        end
        if (!rd_valid) begin
            report_failure("no rd_valid returned for a read");
        end else begin
            check_value("rd_data", rd_data, exp_data);
            if (exp_blank) check_value("mem_req seen on a blank read", req_seen, 1'b0);
            else check_value("mem_addr", mem_addr, exp_addr);
        end
        // A blank byte is still presented after busy has dropped
        while (busy || rd_valid) @(negedge clk);
        read_pending = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_errors) ? "passed" : "failed");
        test_errors = errors;
    endtask

    initial begin
        #(6 * 80 * 12 * 40);
        $display("Error: watchdog expired before the tests completed");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cpu = '0;
        cfg = '{enable: 1'b1, hangul: 1'b0, port: 8'hd8, mask: 8'hfc,
                mem_base: 27'h0400000, mem_size: 8'h10};
        ref_bank1 = 27'h00000;
        ref_bank2 = 27'h20000;
        read_pending = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("mem_req after reset", mem_req, 1'b0);
        check_value("busy after reset", busy, 1'b0);
        check_value("rd_valid after reset", rd_valid, 1'b0);
        io_read(2'd1);
        finish_test("reset");

        // 40 reads run past the end of the glyph and wrap
        io_write(2'd0, 8'h2a);
        io_write(2'd1, 8'h13);
        repeat (40) io_read(2'd1);
        finish_test("glyph");

        // Row near the top of bank 1, folded once the size shrinks to 64 KB
        cfg.mem_size = 8'h08;
        io_write(2'd1, 8'h3c);
        repeat (4) io_read(2'd1);
        cfg.mem_size = 8'h04;
        repeat (4) io_read(2'd1);
        finish_test("masking");

        // Offset 3 goes first so that bit 11 shows what offset 2 wrote
        cfg.mem_size = 8'h10;
        io_write(2'd3, 8'h05);
        io_write(2'd2, 8'h5a);
        repeat (4) io_read(2'd3);
        check_value("bank 2 bit 11 without Hangul", mem_addr[11], 1'b0);
        cfg.hangul = 1'b1;
        io_write(2'd2, 8'h5a);
        repeat (4) io_read(2'd3);
        check_value("bank 2 bit 11 in Hangul mode", mem_addr[11], 1'b1);
        cfg.hangul = 1'b0;
        finish_test("bank2");

        cfg.mem_size = 8'h08;
        repeat (3) io_read(2'd3);
        io_read(2'd0);
        io_read(2'd2);
        cfg.mem_size = 8'h10;
        io_read(2'd3);
        finish_test("blank");

        // Wrong port, m1 high and disabled device must all be ignored
        strobe(1'b0, 1'b1, 1'b0, 8'hc8, 8'h3f);
        strobe(1'b0, 1'b1, 1'b1, cfg.port, 8'h3f);
        strobe(1'b1, 1'b0, 1'b0, 8'hc9, 8'h00);
        strobe(1'b1, 1'b0, 1'b1, cfg.port | 8'h01, 8'h00);
        cfg.enable = 1'b0;
        strobe(1'b0, 1'b1, 1'b0, cfg.port, 8'h3f);
        strobe(1'b1, 1'b0, 1'b0, cfg.port | 8'h01, 8'h00);
        cfg.enable = 1'b1;
        repeat (6) @(negedge clk);
        fork
            io_read(2'd1);
            begin
                wait (busy);
                strobe(1'b0, 1'b1, 1'b0, cfg.port, 8'h3f);
            end
        join
        io_read(2'd1);
        finish_test("decode");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/kanji_pkg.sv
rtl/io_port_decoder.sv
rtl/kanji_addr_gen.sv
rtl/font_mem_port.sv
rtl/kanji_device.sv
dv/font_mem_model.sv
dv/kanji_tb.sv

// File: rtl/font_mem_port.sv
/*
 * Font memory port of the kanji device.
 * Runs a four-phase req/ack handshake for each memory fetch, answers blank
 * fetches locally, and returns one byte with a single rd_valid pulse.
 */
`timescale 1ns/1ns

module font_mem_port (
    input  logic                 clk,
    input  logic                 reset,
    input  kanji_pkg::fetch_t    fetch,
    input  logic                 mem_ack,
    input  logic [7:0]           mem_rdata,
    output logic                 mem_req,
    output kanji_pkg::mem_addr_t mem_addr,
    output logic [7:0]           rd_data,
    output logic                 rd_valid,
    output logic                 busy
);

    import kanji_pkg::*;

    // Request holds mem_req, release waits for the ack to drop,
    // done is the presentation cycle of a blank byte
    typedef enum logic [1:0] {
        state_idle,
        state_request,
        state_release,
        state_done
    } port_state_t;

    port_state_t state;

    assign mem_req = (state == state_request);

    // Busy covers the fetch cycle itself and the whole handshake
    assign busy = fetch.valid || (state == state_request) || (state == state_release);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= state_idle;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            case (state)
                state_idle: begin
                    if (fetch.valid) begin
                        rd_valid <= fetch.blank;
                        state    <= fetch.blank ? state_done : state_request;
                    end
                end
                state_request: begin
                    // Data is valid with the ack, so this is the last word
                    if (mem_ack) begin
                        rd_valid <= 1'b1;
                        state    <= state_release;
                    end
                end
                state_release: begin
                    // No new request until the memory has let go
                    if (!mem_ack) state <= state_idle;
                end
                state_done: state <= state_idle;
                default:    state <= state_idle;
            endcase
        end
    end

    // Address and read byte are plain data registers
    always_ff @(posedge clk) begin
        if (state == state_idle && fetch.valid) begin
            mem_addr <= fetch.addr;
            if (fetch.blank) rd_data <= BLANK_BYTE;
        end
        if (state == state_request && mem_ack) begin
            rd_data <= mem_rdata;
        end
    end

endmodule

// File: rtl/io_port_decoder.sv
/*
 * I/O port decoder of the kanji device.
 * Qualifies CPU I/O cycles against the configured port and mask and turns
 * an accepted strobe into a registered one-cycle command.
 */
`timescale 1ns/1ns

module io_port_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  kanji_pkg::cpu_bus_t   cpu,
    input  kanji_pkg::kanji_cfg_t cfg,
    input  logic                  busy,
    output kanji_pkg::dev_cmd_t   cmd
);

    logic io_cycle;
    logic port_hit;
    logic accept;

    // An opcode fetch also drives iorq during interrupt acknowledge, so m1 must be low
    assign io_cycle = cpu.iorq && !cpu.m1;
    assign port_hit = (cpu.addr & cfg.mask) == cfg.port;

    // The read issued last cycle has not reached the memory port yet, so
    // its command pulse blocks strobes until busy takes over
    assign accept = cpu.req && io_cycle && port_hit && cfg.enable && !busy && !cmd.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.wr <= 1'b0;
            cmd.rd <= 1'b0;
        end else begin
            // Strobes fall back to zero unless a new access is taken
            cmd.wr <= accept && cpu.wr;
            cmd.rd <= accept && cpu.rd;
            if (accept) begin
                // Only the two low address bits select the register
                cmd.offset <= cpu.addr[1:0];
                cmd.data   <= cpu.wdata;
            end
        end
    end

endmodule

// File: rtl/kanji_addr_gen.sv
/*
 * Address generator of the kanji device.
 * Keeps the row and glyph counter of both banks, applies the memory size
 * limits and issues one fetch per accepted read command.
 */
`timescale 1ns/1ns

module kanji_addr_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  kanji_pkg::dev_cmd_t  cmd,
    input  logic                 hangul,
    input  kanji_pkg::mem_addr_t mem_base,
    input  kanji_pkg::mem_size_t mem_size,
    output kanji_pkg::fetch_t    fetch
);

    import kanji_pkg::*;

    // Bank 1 is JIS level 1, bank 2 is level 2 or Hangul
    mem_addr_t  bank1;
    mem_addr_t  bank2;
    mem_addr_t  size_mask;
    logic [6:0] row2_low;
    logic       bank2_present;

    // Advance the byte counter inside one glyph and wrap at its end
    function automatic mem_addr_t glyph_step(input mem_addr_t addr);
        mem_addr_t mask;
        mask = mem_addr_t'(GLYPH_BYTES - 1);
        return (addr & ~mask) | ((addr + 1'b1) & mask);
    endfunction

    // Size in bytes minus one, a zero size leaves the address unmasked
    assign size_mask = (mem_addr_t'(mem_size) << SIZE_UNIT_SHIFT) - mem_addr_t'(1);

    // Hangul uses a seventh row bit in the low half of the bank 2 row
    assign row2_low = hangul ? cmd.data[6:0] : {1'b0, cmd.data[5:0]};

    assign bank2_present = (mem_size == BANK2_SIZE);

    always_ff @(posedge clk) begin
        if (reset) begin
            bank1       <= BANK1_RESET;
            bank2       <= BANK2_RESET;
            fetch.valid <= 1'b0;
        end else begin
            // Every read issues exactly one fetch, blank or not
            fetch.valid <= cmd.rd;

            if (cmd.wr) begin
                // Row writes replace their field and keep the other bits
                case (cmd.offset)
                    2'd0: bank1[10:5]  <= cmd.data[5:0];
                    2'd1: bank1[16:11] <= cmd.data[5:0];
                    2'd2: bank2[11:5]  <= row2_low;
                    2'd3: bank2[16:11] <= cmd.data[5:0];
                    default: ;
                endcase
            end

            if (cmd.rd) begin
                // Default is the blank byte, used by offsets 0 and 2
                fetch.blank <= 1'b1;
                fetch.addr  <= mem_base;
                case (cmd.offset)
                    2'd1: begin
                        fetch.blank <= 1'b0;
                        fetch.addr  <= mem_base + (bank1 & size_mask);
                        bank1       <= glyph_step(bank1);
                    end
                    2'd3: begin
                        // Without the second bank the read is blank
                        // but the counter still moves on
                        if (bank2_present) begin
                            fetch.blank <= 1'b0;
                            fetch.addr  <= mem_base + bank2;
                        end
                        bank2 <= glyph_step(bank2);
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: rtl/kanji_device.sv
/*
 * Top level of the kanji font device.
 * Connects the port decoder, the bank address generator and the font
 * memory port, with the CPU bus and configuration coming in as structs.
 */
`timescale 1ns/1ns

module kanji_device (
    input  logic                  clk,
    input  logic                  reset,
    input  kanji_pkg::cpu_bus_t   cpu,
    input  kanji_pkg::kanji_cfg_t cfg,
    input  logic                  mem_ack,
    input  logic [7:0]            mem_rdata,
    output logic                  mem_req,
    output kanji_pkg::mem_addr_t  mem_addr,
    output logic [7:0]            rd_data,
    output logic                  rd_valid,
    output logic                  busy
);

    import kanji_pkg::*;

    // Accepted CPU access towards the address generator
    dev_cmd_t cmd;
    // Pending read towards the memory port
    fetch_t   fetch;

    io_port_decoder decoder_inst (
        .clk   (clk),
        .reset (reset),
        .cpu   (cpu),
        .cfg   (cfg),
        .busy  (busy),
        .cmd   (cmd)
    );

    kanji_addr_gen addr_gen_inst (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .hangul   (cfg.hangul),
        .mem_base (cfg.mem_base),
        .mem_size (cfg.mem_size),
        .fetch    (fetch)
    );

    // Busy goes back to the decoder as its only back-pressure
    font_mem_port mem_port_inst (
        .clk       (clk),
        .reset     (reset),
        .fetch     (fetch),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .busy      (busy)
    );

endmodule

// File: rtl/kanji_pkg.sv
/*
 * Shared types and constants for the kanji font device.
 * Every RTL block imports this package for the CPU bus, the configuration
 * and the internal command and fetch records.
 */
package kanji_pkg;

    // Byte address into the external font memory
    typedef logic [26:0] mem_addr_t;
    // I/O port number, also used for the port mask
    typedef logic [7:0]  io_port_t;
    // Font memory size counted in 16 KB units
    typedef logic [7:0]  mem_size_t;

    // Reset rows of the two banks, level 2 starts at 128 KB
    localparam mem_addr_t BANK1_RESET     = 27'h00000;
    localparam mem_addr_t BANK2_RESET     = 27'h20000;
    // Shift that turns a size in units into a size in bytes
    localparam int        SIZE_UNIT_SHIFT = 14;
    // Only a 256 KB font carries the second bank
    localparam mem_size_t BANK2_SIZE      = 8'h10;
    localparam logic [7:0] BLANK_BYTE     = 8'hff;
    localparam int        GLYPH_BYTES     = 32;

    // One CPU I/O access, req is a single cycle strobe
    typedef struct packed {
        logic       req;
        logic       iorq;
        logic       m1;
        logic       rd;
        logic       wr;
        io_port_t   addr;
        logic [7:0] wdata;
    } cpu_bus_t;

    // Static device configuration, set before the first access
    typedef struct packed {
        logic      enable;
        logic      hangul;
        io_port_t  port;
        io_port_t  mask;
        mem_addr_t mem_base;
        mem_size_t mem_size;
    } kanji_cfg_t;

    // Accepted access as seen by the address generator
    typedef struct packed {
        logic       wr;
        logic       rd;
        logic [1:0] offset;
        logic [7:0] data;
    } dev_cmd_t;

    // A pending read, blank reads skip the memory
    typedef struct packed {
        logic      valid;
        logic      blank;
        mem_addr_t addr;
    } fetch_t;

endpackage
